/* common/macCmdIf.sv */
`timescale 1ns/1ps

interface macCmdIf;
	import macPkg::*;

	logic valid; // head entry present.
	logic pop; // head taken by the pipeline.
	opcodeT opcode;
	regAddrT rd;
	regAddrT ra;
	regAddrT rb;
	regAddrT rc;
	dataT imm;

	modport queueSide (
		output valid,
		output opcode,
		output rd, ra, rb, rc,
		output imm,
		input pop
	);

	modport pipeSide (
		input valid,
		input opcode,
		input rd, ra, rb, rc,
		input imm,
		output pop
	);

endinterface

/* common/macPkg.sv */
`include "mac_config.svh"

package macPkg;

	// index into the register file.
	typedef logic [$clog2(`MAC_NUM_REGS)-1:0] regAddrT;

	// register contents, two's complement.
	typedef logic signed [`MAC_DATA_WIDTH-1:0] dataT;

	typedef enum logic {
		OP_LOAD = 1'b0, // rd <= imm.
		OP_MAC = 1'b1 // rd <= ra * rb +/- rc.
	} opcodeT;

	// what the issue logic does with the queue head this cycle.
	typedef enum logic [1:0] {
		ISSUE_IDLE = 2'd0, // queue empty.
		ISSUE_STALL = 2'd1, // head waits on an in-flight rd.
		ISSUE_GO = 2'd2 // head is popped.
	} issueStateT;

endpackage

/* common/mac_config.svh */
`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

// register file size.
`define MAC_NUM_REGS 16

// width of one register value.
`define MAC_DATA_WIDTH 16

// command queue entries, equal to the sender's initial credits.
`define MAC_QUEUE_DEPTH 4

`endif

/* design/cmdQueue.sv */
`timescale 1ns/1ps
`include "mac_config.svh"

module cmdQueue (
	input logic clk,
	input logic rstN,
	input logic cmdValid,
	input macPkg::opcodeT cmdOpcode,
	input macPkg::regAddrT cmdRd,
	input macPkg::regAddrT cmdRa,
	input macPkg::regAddrT cmdRb,
	input macPkg::regAddrT cmdRc,
	input macPkg::dataT cmdImm,
	output logic cmdCredit,
	macCmdIf.queueSide cmd
);
	import macPkg::*;

	localparam int DEPTH = `MAC_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	typedef struct packed {
		opcodeT opcode;
		regAddrT rd;
		regAddrT ra;
		regAddrT rb;
		regAddrT rc;
		dataT imm;
	} entryT;

	entryT entries [DEPTH];
	entryT head;
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign push = cmdValid; // host only sends while holding a credit.
	assign pop = cmd.pop;
	assign head = entries[rdPtr];

	assign cmd.valid = (count != '0);
	assign cmd.opcode = head.opcode;
	assign cmd.rd = head.rd;
	assign cmd.ra = head.ra;
	assign cmd.rb = head.rb;
	assign cmd.rc = head.rc;
	assign cmd.imm = head.imm;

	always_ff @(posedge clk) begin
		if (push)
			entries[wrPtr] <= '{cmdOpcode, cmdRd, cmdRa, cmdRb, cmdRc, cmdImm};
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			cmdCredit <= 1'b0;
		end else begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			cmdCredit <= pop; // one credit back per entry freed.
		end
	end

	// the host overran its credits.
	assert property (@(posedge clk) disable iff (!rstN)
		push |-> (count < CNT_W'(DEPTH)))
		else $error("command pushed into a full queue");

	assert property (@(posedge clk) disable iff (!rstN)
		pop |-> (count != '0))
		else $error("command popped from an empty queue");

endmodule

/* design/macTop.sv */
`timescale 1ns/1ps

module macTop (
	input logic clk,
	input logic rstN,
	input logic cmdValid,
	input macPkg::opcodeT cmdOpcode,
	input macPkg::regAddrT cmdRd,
	input macPkg::regAddrT cmdRa,
	input macPkg::regAddrT cmdRb,
	input macPkg::regAddrT cmdRc,
	input macPkg::dataT cmdImm,
	output logic cmdCredit,
	input logic cfgWrite,
	input logic cfgSubtract,
	input logic cfgSaturate,
	output logic resultValid,
	output macPkg::regAddrT resultRd,
	output macPkg::dataT resultData
);
	import macPkg::*;

	macCmdIf cmdBus ();

	logic subtractMode;
	logic saturateMode;
	regAddrT readAddrA;
	regAddrT readAddrB;
	regAddrT readAddrC;
	dataT readDataA;
	dataT readDataB;
	dataT readDataC;
	logic writeEn;
	regAddrT writeAddr;
	dataT writeData;

	cmdQueue uQueue (
		.clk(clk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmdOpcode(cmdOpcode),
		.cmdRd(cmdRd),
		.cmdRa(cmdRa),
		.cmdRb(cmdRb),
		.cmdRc(cmdRc),
		.cmdImm(cmdImm),
		.cmdCredit(cmdCredit),
		.cmd(cmdBus)
	);

	// mode bits sit beside the pipeline.
	macCtrlRegs uCtrl (
		.clk(clk),
		.rstN(rstN),
		.cfgWrite(cfgWrite),
		.cfgSubtract(cfgSubtract),
		.cfgSaturate(cfgSaturate),
		.subtractMode(subtractMode),
		.saturateMode(saturateMode)
	);

	macPipe uPipe (
		.clk(clk),
		.rstN(rstN),
		.cmd(cmdBus),
		.subtractMode(subtractMode),
		.saturateMode(saturateMode),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.readAddrC(readAddrC),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.readDataC(readDataC),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.resultValid(resultValid),
		.resultRd(resultRd),
		.resultData(resultData)
	);

	regFileTriple uRegs (
		.clk(clk),
		.rstN(rstN),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.readAddrC(readAddrC),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.readDataC(readDataC)
	);

endmodule

/* design/macUnit/macCtrlRegs.sv */
`timescale 1ns/1ps

module macCtrlRegs (
	input logic clk,
	input logic rstN,
	input logic cfgWrite,
	input logic cfgSubtract,
	input logic cfgSaturate,
	output logic subtractMode,
	output logic saturateMode
);

	// host writes both bits at once.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			subtractMode <= 1'b0;
			saturateMode <= 1'b0;
		end else if (cfgWrite) begin
			subtractMode <= cfgSubtract; // rc is subtracted.
			saturateMode <= cfgSaturate; // clamp instead of wrap.
		end
	end

endmodule

/* design/macUnit/macPipe.sv */
`timescale 1ns/1ps
`include "mac_config.svh"

module macPipe (
	input logic clk,
	input logic rstN,
	macCmdIf.pipeSide cmd,
	input logic subtractMode,
	input logic saturateMode,
	output macPkg::regAddrT readAddrA,
	output macPkg::regAddrT readAddrB,
	output macPkg::regAddrT readAddrC,
	input macPkg::dataT readDataA,
	input macPkg::dataT readDataB,
	input macPkg::dataT readDataC,
	output logic writeEn,
	output macPkg::regAddrT writeAddr,
	output macPkg::dataT writeData,
	output logic resultValid,
	output macPkg::regAddrT resultRd,
	output macPkg::dataT resultData
);
	import macPkg::*;

	localparam int W = `MAC_DATA_WIDTH;
	localparam dataT SAT_MAX = {1'b0, {(W-1){1'b1}}};
	localparam dataT SAT_MIN = {1'b1, {(W-1){1'b0}}};

	issueStateT issueState;
	logic isMac;
	logic s1Hit;
	logic s2Hit;
	logic hazard;

	logic s1Valid;
	opcodeT s1Op;
	regAddrT s1Rd;
	dataT s1A;
	dataT s1B;
	dataT s1C;
	logic s1Sub;
	logic s1Sat;

	logic s2Valid;
	regAddrT s2Rd;
	dataT s2Data;

	logic signed [2*W-1:0] product;
	logic signed [2*W:0] sum;
	dataT macResult;

	// command names register r as rd, or as a source of a mac.
	function automatic logic headUses(input opcodeT op, input regAddrT rd, input regAddrT ra,
		input regAddrT rb, input regAddrT rc, input regAddrT r);
		return (rd == r) || ((op == OP_MAC) && (ra == r || rb == r || rc == r));
	endfunction

	// operands come straight from the register file.
	assign readAddrA = cmd.ra;
	assign readAddrB = cmd.rb;
	assign readAddrC = cmd.rc;

	// load has no sources, only its rd is compared.
	assign isMac = (cmd.opcode == OP_MAC);
	assign s1Hit = s1Valid && headUses(cmd.opcode, cmd.rd, cmd.ra, cmd.rb, cmd.rc, s1Rd);
	assign s2Hit = s2Valid && headUses(cmd.opcode, cmd.rd, cmd.ra, cmd.rb, cmd.rc, s2Rd);
	assign hazard = s1Hit || s2Hit;

	always_comb begin
		if (!cmd.valid)
			issueState = ISSUE_IDLE;
		else if (hazard)
			issueState = ISSUE_STALL;
		else
			issueState = ISSUE_GO;
	end

	assign cmd.pop = (issueState == ISSUE_GO);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end else begin
			s1Valid <= cmd.pop;
			s2Valid <= s1Valid;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.pop) begin
			s1Op <= cmd.opcode;
			s1Rd <= cmd.rd;
			s1A <= isMac ? readDataA : cmd.imm; // load carries imm in slot a.
			s1B <= readDataB;
			s1C <= readDataC;
			s1Sub <= subtractMode;
			s1Sat <= saturateMode;
		end
		if (s1Valid) begin
			s2Rd <= s1Rd;
			s2Data <= macResult;
		end
	end

	// full precision product, one guard bit for the add.
	always_comb begin
		product = (2*W)'(s1A) * (2*W)'(s1B);
		if (s1Sub)
			sum = (2*W+1)'(product) - (2*W+1)'(s1C);
		else
			sum = (2*W+1)'(product) + (2*W+1)'(s1C);
		if (s1Op == OP_LOAD)
			macResult = s1A;
		else if (s1Sat && sum > (2*W+1)'(SAT_MAX))
			macResult = SAT_MAX;
		else if (s1Sat && sum < (2*W+1)'(SAT_MIN))
			macResult = SAT_MIN;
		else
			macResult = sum[W-1:0]; // wrap.
	end

	assign resultValid = s2Valid;
	assign resultRd = s2Rd;
	assign resultData = s2Data;
	assign writeEn = s2Valid;
	assign writeAddr = s2Rd;
	assign writeData = s2Data;

	// without forwarding, an issue over the rd of either of the last two issues reads stale data.
	assert property (@(posedge clk) disable iff (!rstN)
		cmd.pop |->
			!($past(cmd.pop) &&
				headUses(cmd.opcode, cmd.rd, cmd.ra, cmd.rb, cmd.rc, $past(cmd.rd))) &&
			!($past(cmd.pop, 2) &&
				headUses(cmd.opcode, cmd.rd, cmd.ra, cmd.rb, cmd.rc, $past(cmd.rd, 2))))
		else $error("command issued over a register hazard");

endmodule

/* design/regFile/regFileTriple.sv */
`timescale 1ns/1ps
`include "mac_config.svh"

module regFileTriple (
	input logic clk,
	input logic rstN,
	input logic writeEn,
	input macPkg::regAddrT writeAddr,
	input macPkg::dataT writeData,
	input macPkg::regAddrT readAddrA,
	input macPkg::regAddrT readAddrB,
	input macPkg::regAddrT readAddrC,
	output macPkg::dataT readDataA,
	output macPkg::dataT readDataB,
	output macPkg::dataT readDataC
);
	import macPkg::*;

	dataT regs [`MAC_NUM_REGS];

	// three independent read ports, no write bypass.
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];
	assign readDataC = regs[readAddrC];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			regs <= '{default: '0}; // registers read as zero after reset.
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// an unknown address would corrupt an arbitrary register.
	assert property (@(posedge clk) disable iff (!rstN)
		writeEn |-> !$isunknown(writeAddr))
		else $error("register write with unknown address");

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator and run; pass only if the log holds the pass line.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator -Wno-fatal --binary --timing --assert -f vlog.f --top-module macTb -o macSim \
	&& ./obj_dir/macSim > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log 2>/dev/null && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* testbench/macTb.sv */
`timescale 1ns/1ps
`include "mac_config.svh"

module macTb;
	import macPkg::*;

	localparam int DEPTH = `MAC_QUEUE_DEPTH;
	localparam int MACS_PER_PHASE = 60;
	localparam int CHAIN_LEN = 24;
	localparam int TOTAL_CMDS = 1 + 2*`MAC_NUM_REGS + 4*MACS_PER_PHASE + CHAIN_LEN;
	localparam int TIMEOUT_CYCLES = 16 + TOTAL_CMDS*8 + 200;
	localparam longint MAX_VAL = (longint'(1) << (`MAC_DATA_WIDTH-1)) - 1;
	localparam longint MIN_VAL = -MAX_VAL - 1;

	typedef struct packed {
		regAddrT rd;
		dataT data;
	} expT;

	logic clk;
	logic rstN;
	logic cmdValid;
	opcodeT cmdOpcode;
	regAddrT cmdRd;
	regAddrT cmdRa;
	regAddrT cmdRb;
	regAddrT cmdRc;
	dataT cmdImm;
	logic cmdCredit;
	logic cfgWrite;
	logic cfgSubtract;
	logic cfgSaturate;
	logic resultValid;
	regAddrT resultRd;
	dataT resultData;

	logic [31:0] rngState = 32'd46709;
	int credits = DEPTH;
	logic subMode = 1'b0;
	logic satMode = 1'b0;
	dataT model [`MAC_NUM_REGS];
	expT expQ [$];

	macTop DUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#(TIMEOUT_CYCLES * 20);
		$display("watchdog expired: commands never completed");
		$display("TESTS FAILED");
		$fatal(1);
	end

	function automatic logic [31:0] xorshift32();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	// a quarter near each signed limit, so squares overflow.
	function automatic dataT randData();
		logic [31:0] r;
		r = xorshift32();
		case (r[1:0])
			2'd0: return {1'b0, 7'h7f, r[15:8]};
			2'd1: return {1'b1, 7'h00, r[15:8]};
			default: return r[31:16];
		endcase
	endfunction

	function automatic dataT macModel(input dataT a, input dataT b, input dataT c);
		longint p;
		longint s;
		p = longint'(a) * longint'(b);
		s = subMode ? p - longint'(c) : p + longint'(c);
		if (satMode && s > MAX_VAL)
			return dataT'(MAX_VAL);
		if (satMode && s < MIN_VAL)
			return dataT'(MIN_VAL);
		return dataT'(s); // keep low bits.
	endfunction

	task automatic checkEq(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, want);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	// outputs are stable at the falling edge.
	task automatic nextCycle();
		expT e;
		@(negedge clk);
		if (cmdCredit) begin
			credits++;
			checkEq(32'(credits > DEPTH), 32'd0, "credit returned beyond queue depth");
		end
		if (resultValid) begin
			if (expQ.size() == 0) begin
				$display("result arrived while no command was outstanding");
				$display("TESTS FAILED");
				$fatal(1);
			end
			e = expQ.pop_front();
			checkEq(32'(resultRd), 32'(e.rd), "result destination");
			checkEq(32'(resultData), 32'(e.data), "result value");
		end
	endtask

	task automatic sendCmd(input opcodeT op, input regAddrT rd, input regAddrT ra,
		input regAddrT rb, input regAddrT rc, input dataT imm);
		dataT val;
		nextCycle();
		while (credits == 0) begin
			cmdValid = 1'b0;
			nextCycle();
		end
		cmdValid = 1'b1;
		cmdOpcode = op;
		cmdRd = rd;
		cmdRa = ra;
		cmdRb = rb;
		cmdRc = rc;
		cmdImm = imm;
		credits--;
		val = (op == OP_LOAD) ? imm : macModel(model[ra], model[rb], model[rc]);
		model[rd] = val; // commands retire in order.
		expQ.push_back('{rd, val});
	endtask

	task automatic drain();
		nextCycle();
		cmdValid = 1'b0;
		while (credits != DEPTH || expQ.size() != 0)
			nextCycle();
	endtask

	task automatic configure(input logic sub, input logic sat);
		drain();
		cfgWrite = 1'b1;
		cfgSubtract = sub;
		cfgSaturate = sat;
		nextCycle();
		cfgWrite = 1'b0;
		subMode = sub;
		satMode = sat;
	endtask

	task automatic loadAll();
		for (int i = 0; i < `MAC_NUM_REGS; i++)
			sendCmd(OP_LOAD, regAddrT'(i), '0, '0, '0, randData());
	endtask

	// mostly MACs with an occasional LOAD.
	task automatic runMacs(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = xorshift32();
			if (r[2:0] == 3'd0)
				sendCmd(OP_LOAD, r[7:4], '0, '0, '0, randData());
			else
				sendCmd(OP_MAC, r[7:4], r[11:8], r[15:12], r[19:16], '0);
		end
	endtask

	task automatic runChain(input int n);
		logic [31:0] r;
		regAddrT prev;
		prev = regAddrT'(xorshift32());
		for (int i = 0; i < n; i++) begin
			r = xorshift32();
			sendCmd(OP_MAC, r[7:4], prev, r[11:8], prev, '0); // reads the last rd.
			prev = r[7:4];
		end
	endtask

	initial begin
		rstN = 1'b0;
		cmdValid = 1'b0;
		cmdOpcode = OP_LOAD;
		cmdRd = '0;
		cmdRa = '0;
		cmdRb = '0;
		cmdRc = '0;
		cmdImm = '0;
		cfgWrite = 1'b0;
		cfgSubtract = 1'b0;
		cfgSaturate = 1'b0;
		for (int i = 0; i < `MAC_NUM_REGS; i++)
			model[i] = '0;
		repeat (16) begin
			@(negedge clk);
			checkEq(32'(cmdCredit), 32'd0, "credit during reset");
			checkEq(32'(resultValid), 32'd0, "result during reset");
		end
		rstN = 1'b1;
		repeat (3) begin
			nextCycle();
			checkEq(32'(cmdCredit), 32'd0, "credit with no command sent");
			checkEq(32'(resultValid), 32'd0, "result with no command sent");
		end
		sendCmd(OP_MAC, 4'd4, 4'd1, 4'd2, 4'd3, '0); // all registers still zero.
		drain();
		loadAll();
		runMacs(MACS_PER_PHASE);
		configure(1'b1, 1'b0);
		runMacs(MACS_PER_PHASE);
		configure(1'b0, 1'b1);
		loadAll();
		runMacs(MACS_PER_PHASE);
		configure(1'b1, 1'b1);
		runMacs(MACS_PER_PHASE);
		configure(1'b0, 1'b0);
		runChain(CHAIN_LEN);
		drain();
		// every command has its result and credit, nothing more may follow.
		repeat (8) begin
			nextCycle();
			checkEq(32'(cmdCredit), 32'd0, "credit after all commands retired");
			checkEq(32'(resultValid), 32'd0, "result after all commands retired");
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+common
common/macPkg.sv
common/macCmdIf.sv
design/regFile/regFileTriple.sv
design/cmdQueue.sv
design/macUnit/macCtrlRegs.sv
design/macUnit/macPipe.sv
design/macTop.sv
testbench/macTb.sv
